/* Bender.yml */
package:
  name: mc_dram_bridge

sources:
  - mc_bridge_pkg.sv
  - mc_dram_hash.sv
  - mc_req_issuer.sv
  - mc_return_reorder.sv
  - mc_dram_bridge.sv
  - target: simulation
    files:
      - tb_net_model.sv
      - tb_mc_dram_bridge.sv

/* build.f */
mc_bridge_pkg.sv
mc_dram_hash.sv
mc_req_issuer.sv
mc_return_reorder.sv
mc_dram_bridge.sv
tb_net_model.sv
tb_mc_dram_bridge.sv

/* mc_bridge_pkg.sv */
package mc_bridge_pkg;

  // ------------------------------
  // memory port
  // ------------------------------
  localparam int PADDR_WIDTH_LP = 28;
  localparam int DATA_WIDTH_LP = 32;
  // byte address with the byte-in-word bits removed
  localparam int WORD_ADDR_WIDTH_LP = PADDR_WIDTH_LP - 2;

  // ------------------------------
  // manycore network
  // ------------------------------
  localparam int NET_ADDR_WIDTH_LP = 20;
  localparam int X_CORD_WIDTH_LP = 4;
  localparam int Y_CORD_WIDTH_LP = 2;
  localparam int NET_CREDITS_LP = 4;
  localparam int CREDIT_WIDTH_LP = 3;

  // vcache geometry, one pod
  localparam int NUM_VCACHE_COLS_LP = 4;
  localparam int NUM_VCACHE_ROWS_LP = 2;
  localparam int VCACHE_BLOCK_WORDS_LP = 4;
  localparam int COL_SEL_WIDTH_LP = $clog2(NUM_VCACHE_COLS_LP);
  localparam int ROW_SEL_WIDTH_LP = $clog2(NUM_VCACHE_ROWS_LP);
  localparam int BLOCK_OFS_WIDTH_LP = $clog2(VCACHE_BLOCK_WORDS_LP);
  // north row sits above the compute array, south row below it
  localparam logic [Y_CORD_WIDTH_LP-1:0] VCACHE_NORTH_Y_LP = Y_CORD_WIDTH_LP'(0);
  localparam logic [Y_CORD_WIDTH_LP-1:0] VCACHE_SOUTH_Y_LP = Y_CORD_WIDTH_LP'(3);

  // reorder buffer
  localparam int OUTSTANDING_LP = 8;
  localparam int ID_WIDTH_LP = 3;

  typedef enum logic {
    MEM_OP_RD = 1'b0,
    MEM_OP_WR = 1'b1
  } mem_op_e;

  typedef enum logic {
    NET_OP_LOAD  = 1'b0,
    NET_OP_STORE = 1'b1
  } net_op_e;

endpackage

/* mc_dram_bridge.sv */
module mc_dram_bridge
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,

    // memory forward
    input  logic                                         mem_fwd_v_i,
    input  mc_bridge_pkg::mem_op_e                       mem_fwd_op_i,
    input  logic [mc_bridge_pkg::PADDR_WIDTH_LP-1:0]     mem_fwd_addr_i,
    input  logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]      mem_fwd_data_i,
    output logic                                         mem_fwd_ready_o,

    // memory reverse
    output logic                                         mem_rev_v_o,
    output mc_bridge_pkg::mem_op_e                       mem_rev_op_o,
    output logic [mc_bridge_pkg::PADDR_WIDTH_LP-1:0]     mem_rev_addr_o,
    output logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]      mem_rev_data_o,
    input  logic                                         mem_rev_ready_i,

    // network request
    output logic                                         net_req_v_o,
    output mc_bridge_pkg::net_op_e                       net_req_op_o,
    output logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    net_req_x_o,
    output logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]    net_req_y_o,
    output logic [mc_bridge_pkg::NET_ADDR_WIDTH_LP-1:0]  net_req_addr_o,
    output logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]      net_req_data_o,
    output logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]        net_req_id_o,
    output logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    net_req_src_x_o,
    output logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]    net_req_src_y_o,
    input  logic                                         net_credit_i,

    // network response
    input  logic                                         net_resp_v_i,
    input  logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]        net_resp_id_i,
    input  logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]      net_resp_data_i,

    // configuration
    input  logic [mc_bridge_pkg::WORD_ADDR_WIDTH_LP-1:0] dram_offset_i,
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    dram_pod_x_i,
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    global_x_i,
    input  logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]    global_y_i
  );

  import mc_bridge_pkg::*;

  logic                         alloc_v;
  logic [ID_WIDTH_LP-1:0]       alloc_id;
  logic                         alloc_yumi;
  logic [X_CORD_WIDTH_LP-1:0]   hash_x;
  logic [Y_CORD_WIDTH_LP-1:0]   hash_y;
  logic [NET_ADDR_WIDTH_LP-1:0] hash_addr;

  // ------------------------------
  // outgoing request
  // ------------------------------
  mc_req_issuer u_issuer
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_fwd_v_i     (mem_fwd_v_i),
    .mem_fwd_op_i    (mem_fwd_op_i),
    .mem_fwd_data_i  (mem_fwd_data_i),
    .mem_fwd_ready_o (mem_fwd_ready_o),
    .alloc_v_i       (alloc_v),
    .alloc_id_i      (alloc_id),
    .alloc_yumi_o    (alloc_yumi),
    .hash_x_i        (hash_x),
    .hash_y_i        (hash_y),
    .hash_addr_i     (hash_addr),
    .net_credit_i    (net_credit_i),
    .global_x_i      (global_x_i),
    .global_y_i      (global_y_i),
    .net_req_v_o     (net_req_v_o),
    .net_req_op_o    (net_req_op_o),
    .net_req_x_o     (net_req_x_o),
    .net_req_y_o     (net_req_y_o),
    .net_req_addr_o  (net_req_addr_o),
    .net_req_data_o  (net_req_data_o),
    .net_req_id_o    (net_req_id_o),
    .net_req_src_x_o (net_req_src_x_o),
    .net_req_src_y_o (net_req_src_y_o)
  );

  // word address straight from the request, byte bits dropped
  mc_dram_hash u_hash
  (
    .eva_i    (mem_fwd_addr_i[PADDR_WIDTH_LP-1:2]),
    .offset_i (dram_offset_i),
    .pod_x_i  (dram_pod_x_i),
    .x_o      (hash_x),
    .y_o      (hash_y),
    .addr_o   (hash_addr)
  );

  // ------------------------------
  // returning responses
  // ------------------------------
  mc_return_reorder u_reorder
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .alloc_v_o       (alloc_v),
    .alloc_id_o      (alloc_id),
    .alloc_yumi_i    (alloc_yumi),
    .alloc_op_i      (mem_fwd_op_i),
    .alloc_addr_i    (mem_fwd_addr_i),
    .net_resp_v_i    (net_resp_v_i),
    .net_resp_id_i   (net_resp_id_i),
    .net_resp_data_i (net_resp_data_i),
    .mem_rev_v_o     (mem_rev_v_o),
    .mem_rev_op_o    (mem_rev_op_o),
    .mem_rev_addr_o  (mem_rev_addr_o),
    .mem_rev_data_o  (mem_rev_data_o),
    .mem_rev_ready_i (mem_rev_ready_i)
  );

endmodule

/* mc_dram_hash.sv */
module mc_dram_hash
  (
    input  logic [mc_bridge_pkg::WORD_ADDR_WIDTH_LP-1:0] eva_i,
    input  logic [mc_bridge_pkg::WORD_ADDR_WIDTH_LP-1:0] offset_i,
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    pod_x_i,
    output logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]    x_o,
    output logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]    y_o,
    output logic [mc_bridge_pkg::NET_ADDR_WIDTH_LP-1:0]  addr_o
  );

  import mc_bridge_pkg::*;

  logic [WORD_ADDR_WIDTH_LP-1:0]                    eva;
  logic [WORD_ADDR_WIDTH_LP-BLOCK_OFS_WIDTH_LP-1:0] block;
  logic [ROW_SEL_WIDTH_LP-1:0]                      row_sel;
  logic [WORD_ADDR_WIDTH_LP-BLOCK_OFS_WIDTH_LP-COL_SEL_WIDTH_LP-ROW_SEL_WIDTH_LP-1:0] tile_block;

  // offset moves the bridge window into the dram region
  assign eva = eva_i + offset_i;
  assign block = eva[WORD_ADDR_WIDTH_LP-1:BLOCK_OFS_WIDTH_LP];

  // consecutive blocks walk across the columns of the pod
  assign x_o = (pod_x_i << COL_SEL_WIDTH_LP)
             + X_CORD_WIDTH_LP'(block[COL_SEL_WIDTH_LP-1:0]);

  // every other group of columns flips between north and south
  assign row_sel = block[COL_SEL_WIDTH_LP +: ROW_SEL_WIDTH_LP];
  assign y_o = (row_sel == '0) ? VCACHE_NORTH_Y_LP : VCACHE_SOUTH_Y_LP;

  // bits above the tile select, rebuilt with the word-in-block offset
  assign tile_block = block[$bits(block)-1:COL_SEL_WIDTH_LP+ROW_SEL_WIDTH_LP];
  assign addr_o = NET_ADDR_WIDTH_LP'({tile_block, eva[BLOCK_OFS_WIDTH_LP-1:0]});

endmodule

/* mc_req_issuer.sv */
module mc_req_issuer
  (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    // memory forward
    input  logic                                        mem_fwd_v_i,
    input  mc_bridge_pkg::mem_op_e                      mem_fwd_op_i,
    input  logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]     mem_fwd_data_i,
    output logic                                        mem_fwd_ready_o,

    // reorder buffer
    input  logic                                        alloc_v_i,
    input  logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]       alloc_id_i,
    output logic                                        alloc_yumi_o,

    // tile fields from the hash
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]   hash_x_i,
    input  logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]   hash_y_i,
    input  logic [mc_bridge_pkg::NET_ADDR_WIDTH_LP-1:0] hash_addr_i,

    // network request
    input  logic                                        net_credit_i,
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]   global_x_i,
    input  logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]   global_y_i,
    output logic                                        net_req_v_o,
    output mc_bridge_pkg::net_op_e                      net_req_op_o,
    output logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]   net_req_x_o,
    output logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]   net_req_y_o,
    output logic [mc_bridge_pkg::NET_ADDR_WIDTH_LP-1:0] net_req_addr_o,
    output logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]     net_req_data_o,
    output logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]       net_req_id_o,
    output logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]   net_req_src_x_o,
    output logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]   net_req_src_y_o
  );

  import mc_bridge_pkg::*;

  logic [CREDIT_WIDTH_LP-1:0] credit_r;
  logic                       has_credit;
  logic                       issue;

  // ------------------------------
  // acceptance
  // ------------------------------
  assign has_credit = (credit_r != '0);
  assign mem_fwd_ready_o = mem_fwd_v_i & alloc_v_i & has_credit;
  // ready already includes valid, so ready alone marks the transfer
  assign issue = mem_fwd_ready_o;
  assign alloc_yumi_o = issue;

  // outbound credits, one spent per packet
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_r <= CREDIT_WIDTH_LP'(NET_CREDITS_LP);
    end
    else
    begin
      case ({issue, net_credit_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  // ------------------------------
  // packet fields
  // ------------------------------
  always_comb
  begin
    case (mem_fwd_op_i)
      MEM_OP_WR: net_req_op_o = NET_OP_STORE;
      default:   net_req_op_o = NET_OP_LOAD;
    endcase
  end

  assign net_req_v_o = issue;
  assign net_req_x_o = hash_x_i;
  assign net_req_y_o = hash_y_i;
  assign net_req_addr_o = hash_addr_i;
  assign net_req_data_o = mem_fwd_data_i;
  // id rides in the register tag and comes back with the response
  assign net_req_id_o = alloc_id_i;
  assign net_req_src_x_o = global_x_i;
  assign net_req_src_y_o = global_y_i;

endmodule

/* mc_return_reorder.sv */
module mc_return_reorder
  (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    // allocation
    output logic                                    alloc_v_o,
    output logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]   alloc_id_o,
    input  logic                                    alloc_yumi_i,
    input  mc_bridge_pkg::mem_op_e                  alloc_op_i,
    input  logic [mc_bridge_pkg::PADDR_WIDTH_LP-1:0] alloc_addr_i,

    // network response
    input  logic                                    net_resp_v_i,
    input  logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]   net_resp_id_i,
    input  logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0] net_resp_data_i,

    // memory reverse
    output logic                                    mem_rev_v_o,
    output mc_bridge_pkg::mem_op_e                  mem_rev_op_o,
    output logic [mc_bridge_pkg::PADDR_WIDTH_LP-1:0] mem_rev_addr_o,
    output logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0] mem_rev_data_o,
    input  logic                                    mem_rev_ready_i
  );

  import mc_bridge_pkg::*;

  logic [ID_WIDTH_LP-1:0]    alloc_ptr_r;
  logic [ID_WIDTH_LP-1:0]    deq_ptr_r;
  logic [OUTSTANDING_LP-1:0] valid_r;
  logic [OUTSTANDING_LP-1:0] done_r;
  logic                      deq;

  // per-id header and returned word
  mem_op_e                   op_mem   [OUTSTANDING_LP];
  logic [PADDR_WIDTH_LP-1:0] addr_mem [OUTSTANDING_LP];
  logic [DATA_WIDTH_LP-1:0]  data_mem [OUTSTANDING_LP];

  // ------------------------------
  // allocate and dequeue
  // ------------------------------
  // slots free up in order, so only the allocate slot needs checking
  assign alloc_v_o = ~valid_r[alloc_ptr_r];
  assign alloc_id_o = alloc_ptr_r;

  // head waits for its own response even if younger ones are done
  assign mem_rev_v_o = valid_r[deq_ptr_r] & done_r[deq_ptr_r];
  assign deq = mem_rev_v_o & mem_rev_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_r <= '0;
      deq_ptr_r <= '0;
      valid_r <= '0;
      done_r <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
      begin
        valid_r[alloc_ptr_r] <= 1'b1;
        done_r[alloc_ptr_r] <= 1'b0;
        alloc_ptr_r <= alloc_ptr_r + 1'b1;
      end
      if (net_resp_v_i)
      begin
        done_r[net_resp_id_i] <= 1'b1;
      end
      if (deq)
      begin
        valid_r[deq_ptr_r] <= 1'b0;
        deq_ptr_r <= deq_ptr_r + 1'b1;
      end
    end
  end

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (alloc_yumi_i)
    begin
      op_mem[alloc_ptr_r] <= alloc_op_i;
      addr_mem[alloc_ptr_r] <= alloc_addr_i;
    end
    if (net_resp_v_i)
    begin
      data_mem[net_resp_id_i] <= net_resp_data_i;
    end
  end

  assign mem_rev_op_o = op_mem[deq_ptr_r];
  assign mem_rev_addr_o = addr_mem[deq_ptr_r];
  // store responses come back without data
  assign mem_rev_data_o = (op_mem[deq_ptr_r] == MEM_OP_WR) ? '0 : data_mem[deq_ptr_r];

endmodule

/* tb_input.txt */
# op (0 read, 1 write), byte address (hex), write data (hex), flag
# flag 1 holds mem_rev_ready_i low until all ids fill, flag 2 withholds network credits
1 0000100 a5a50001 0
1 0000114 a5a50002 0
1 0000128 a5a50003 0
1 000013c a5a50004 0
1 0000150 a5a50005 0
0 0000114 00000000 0
0 0000100 00000000 0
0 0000150 00000000 0
0 0000300 00000000 0
1 0000100 5a5a0006 2
1 0000184 5a5a0007 0
0 0000100 00000000 0
0 000013c 00000000 0
1 0000208 5a5a0008 0
0 0000184 00000000 0
0 0000208 00000000 0
1 0000404 c3c30009 1
0 0000404 00000000 0
1 0000110 c3c3000a 0
0 0000128 00000000 0
0 0000110 00000000 0
1 0000128 c3c3000b 0
0 0000128 00000000 0
0 0000150 00000000 0
0 0000504 00000000 0
1 0000604 c3c3000c 0
0 0000604 00000000 0
0 000013c 00000000 0

/* tb_mc_dram_bridge.sv */
module tb_mc_dram_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  import mc_bridge_pkg::*;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          mem_fwd_v_i;
  mem_op_e                       mem_fwd_op_i;
  logic [PADDR_WIDTH_LP-1:0]     mem_fwd_addr_i;
  logic [DATA_WIDTH_LP-1:0]      mem_fwd_data_i;
  logic                          mem_fwd_ready_o;
  logic                          mem_rev_v_o;
  mem_op_e                       mem_rev_op_o;
  logic [PADDR_WIDTH_LP-1:0]     mem_rev_addr_o;
  logic [DATA_WIDTH_LP-1:0]      mem_rev_data_o;
  logic                          mem_rev_ready_i;
  logic                          net_req_v_o;
  net_op_e                       net_req_op_o;
  logic [X_CORD_WIDTH_LP-1:0]    net_req_x_o, net_req_src_x_o;
  logic [Y_CORD_WIDTH_LP-1:0]    net_req_y_o, net_req_src_y_o;
  logic [NET_ADDR_WIDTH_LP-1:0]  net_req_addr_o;
  logic [DATA_WIDTH_LP-1:0]      net_req_data_o, net_resp_data_i;
  logic [ID_WIDTH_LP-1:0]        net_req_id_o, net_resp_id_i;
  logic                          net_credit_i;
  logic                          net_resp_v_i;
  logic [WORD_ADDR_WIDTH_LP-1:0] dram_offset_i;
  logic [X_CORD_WIDTH_LP-1:0]    dram_pod_x_i, global_x_i;
  logic [Y_CORD_WIDTH_LP-1:0]    global_y_i;

  int errors, checks, issued, returned, hold_cycles;
  int accepted;
  logic rev_stalled, run_aborted, held_v;
  mem_op_e held_op;
  logic [PADDR_WIDTH_LP-1:0] held_addr;
  logic [DATA_WIDTH_LP-1:0]  held_data;

  // scoreboard in request order, shadow memory by byte address
  mem_op_e                   exp_op_q [$];
  logic [PADDR_WIDTH_LP-1:0] exp_addr_q [$];
  logic [DATA_WIDTH_LP-1:0]  exp_data_q [$];
  logic [DATA_WIDTH_LP-1:0]  shadow [logic [PADDR_WIDTH_LP-1:0]];

  always #10 clk_i = ~clk_i;

  mc_dram_bridge u_dut (.*);

  tb_net_model u_net
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_v_i        (net_req_v_o),
    .req_op_i       (net_req_op_o),
    .req_x_i        (net_req_x_o),
    .req_y_i        (net_req_y_o),
    .req_addr_i     (net_req_addr_o),
    .req_data_i     (net_req_data_o),
    .req_id_i       (net_req_id_o),
    .hold_credits_i (hold_cycles != 0),
    .credit_o       (net_credit_i),
    .resp_v_o       (net_resp_v_i),
    .resp_id_o      (net_resp_id_i),
    .resp_data_o    (net_resp_data_i)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // vcache tile for a byte address, straight from the striping rule
  task automatic expected_tile(input logic [PADDR_WIDTH_LP-1:0] addr,
                               output logic [X_CORD_WIDTH_LP-1:0] x,
                               output logic [Y_CORD_WIDTH_LP-1:0] y,
                               output logic [NET_ADDR_WIDTH_LP-1:0] a);
    logic [WORD_ADDR_WIDTH_LP-1:0] eva;
    logic [WORD_ADDR_WIDTH_LP-1:0] block;
    eva = addr / 4 + dram_offset_i;
    block = eva / 4;
    x = dram_pod_x_i * 4 + block % 4;
    y = ((block / 4) % 2 == 0) ? 0 : 3;
    a = (block / 8) * 4 + eva % 4;
  endtask

  // ------------------------------
  // one request from the file
  // ------------------------------
  task automatic send_request(input mem_op_e op, input logic [PADDR_WIDTH_LP-1:0] addr,
                              input logic [DATA_WIDTH_LP-1:0] data, input int flag);
    logic [X_CORD_WIDTH_LP-1:0]   x;
    logic [Y_CORD_WIDTH_LP-1:0]   y;
    logic [NET_ADDR_WIDTH_LP-1:0] a;
    int waited;
    int full_cycles;
    expected_tile(addr, x, y, a);
    waited = 0;
    full_cycles = 0;
    @(posedge clk_i);
    #2;
    mem_fwd_v_i = 1'b1;
    mem_fwd_op_i = op;
    mem_fwd_addr_i = addr;
    mem_fwd_data_i = data;
    if (flag == 1)
    begin
      mem_rev_ready_i = 1'b0;
      rev_stalled = 1'b1;
    end
    if (flag == 2)
      hold_cycles = 30;
    forever
    begin
      @(negedge clk_i);
      assert (!(mem_fwd_ready_o && exp_op_q.size() >= OUTSTANDING_LP))
      else report_problem("request accepted with all ids in use");
      if (mem_fwd_ready_o)
        break;
      waited++;
      if (rev_stalled && exp_op_q.size() >= OUTSTANDING_LP)
        full_cycles++;
      if (full_cycles == 20)
      begin
        // every id taken for a while, let the consumer drain again
        @(posedge clk_i);
        #2;
        mem_rev_ready_i = 1'b1;
        rev_stalled = 1'b0;
        full_cycles = 0;
      end
      assert (waited < 200)
      else
      begin
        report_problem("timeout waiting for mem_fwd_ready_o");
        run_aborted = 1'b1;
        return;
      end
    end
    check_value("net_req_v_o", 1, net_req_v_o);
    check_value("net_req_op_o", (op == MEM_OP_WR) ? NET_OP_STORE : NET_OP_LOAD, net_req_op_o);
    check_value("net_req_x_o", x, net_req_x_o);
    check_value("net_req_y_o", y, net_req_y_o);
    check_value("net_req_addr_o", a, net_req_addr_o);
    check_value("net_req_src_x_o", global_x_i, net_req_src_x_o);
    check_value("net_req_src_y_o", global_y_i, net_req_src_y_o);
    // ids come out of the circular buffer in turn
    check_value("net_req_id_o", accepted % OUTSTANDING_LP, net_req_id_o);
    accepted++;
    if (op == MEM_OP_WR)
    begin
      check_value("net_req_data_o", data, net_req_data_o);
      shadow[addr] = data;
      exp_data_q.push_back('0);
    end
    else if (shadow.exists(addr))
      exp_data_q.push_back(shadow[addr]);
    else
      exp_data_q.push_back({4'hf, 2'b00, x, y, a});
    exp_op_q.push_back(op);
    exp_addr_q.push_back(addr);
  endtask

  // ------------------------------
  // response and credit monitor
  // ------------------------------
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (mem_rev_v_o && mem_rev_ready_i)
      begin
        assert (exp_op_q.size() != 0)
        else report_problem("memory response with no request outstanding");
        if (exp_op_q.size() != 0)
        begin
          check_value("mem_rev_op_o", exp_op_q.pop_front(), mem_rev_op_o);
          check_value("mem_rev_addr_o", exp_addr_q.pop_front(), mem_rev_addr_o);
          check_value("mem_rev_data_o", exp_data_q.pop_front(), mem_rev_data_o);
        end
      end
      // stalled head must not move
      if (mem_rev_v_o && !mem_rev_ready_i)
      begin
        if (held_v)
        begin
          check_value("mem_rev_op_o while stalled", held_op, mem_rev_op_o);
          check_value("mem_rev_addr_o while stalled", held_addr, mem_rev_addr_o);
          check_value("mem_rev_data_o while stalled", held_data, mem_rev_data_o);
        end
        held_v = 1'b1;
        held_op = mem_rev_op_o;
        held_addr = mem_rev_addr_o;
        held_data = mem_rev_data_o;
      end
      else
      begin
        assert (!held_v || mem_rev_ready_i)
        else report_problem("stalled memory response disappeared");
        held_v = 1'b0;
      end
      if (net_req_v_o)
        issued++;
      assert (issued <= returned + NET_CREDITS_LP)
      else report_problem("packet issued without a credit");
      if (net_credit_i)
        returned++;
    end
  end

  always @(negedge clk_i)
  begin
    if (hold_cycles > 0)
      hold_cycles--;
  end

  initial
  begin
    int fd;
    int n;
    int op_val;
    int flag;
    int waited;
    string line;
    logic [PADDR_WIDTH_LP-1:0] addr;
    logic [DATA_WIDTH_LP-1:0]  data;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    mem_fwd_v_i = 1'b0;
    mem_fwd_op_i = MEM_OP_RD;
    mem_fwd_addr_i = '0;
    mem_fwd_data_i = '0;
    mem_rev_ready_i = 1'b1;
    dram_offset_i = 26'h40;
    dram_pod_x_i = 4'd1;
    global_x_i = 4'd2;
    global_y_i = 2'd1;
    errors = 0;
    checks = 0;
    issued = 0;
    returned = 0;
    hold_cycles = 0;
    accepted = 0;
    rev_stalled = 1'b0;
    run_aborted = 1'b0;
    held_v = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // idle outputs before any request
    @(negedge clk_i);
    check_value("mem_fwd_ready_o", 0, mem_fwd_ready_o);
    check_value("net_req_v_o", 0, net_req_v_o);
    check_value("mem_rev_v_o", 0, mem_rev_v_o);

    fd = $fopen("tb_input.txt", "r");
    assert (fd != 0)
    else
    begin
      report_problem("cannot open tb_input.txt");
      run_aborted = 1'b1;
    end
    while (fd != 0 && !run_aborted && !$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n == 0 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%d %h %h %d", op_val, addr, data, flag);
      if (n == 4)
        send_request(mem_op_e'(op_val[0]), addr, data, flag);
    end
    if (fd != 0)
      $fclose(fd);

    @(posedge clk_i);
    #2;
    mem_fwd_v_i = 1'b0;
    if (rev_stalled)
    begin
      report_problem("response stall ended before all ids were in use");
      mem_rev_ready_i = 1'b1;
    end
    waited = 0;
    while (!run_aborted && exp_op_q.size() != 0)
    begin
      @(negedge clk_i);
      waited++;
      assert (waited < 500)
      else
      begin
        report_problem("timeout draining memory responses");
        run_aborted = 1'b1;
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* tb_net_model.sv */
module tb_net_model
  (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        req_v_i,
    input  mc_bridge_pkg::net_op_e                      req_op_i,
    input  logic [mc_bridge_pkg::X_CORD_WIDTH_LP-1:0]   req_x_i,
    input  logic [mc_bridge_pkg::Y_CORD_WIDTH_LP-1:0]   req_y_i,
    input  logic [mc_bridge_pkg::NET_ADDR_WIDTH_LP-1:0] req_addr_i,
    input  logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]     req_data_i,
    input  logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]       req_id_i,
    input  logic                                        hold_credits_i,
    output logic                                        credit_o,
    output logic                                        resp_v_o,
    output logic [mc_bridge_pkg::ID_WIDTH_LP-1:0]       resp_id_o,
    output logic [mc_bridge_pkg::DATA_WIDTH_LP-1:0]     resp_data_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  import mc_bridge_pkg::*;

  logic [31:0]              rand_state;
  int unsigned              cycle;
  logic                     credit_ok;
  // dram contents keyed by {x, y, tile address}
  logic [DATA_WIDTH_LP-1:0] dram [logic [X_CORD_WIDTH_LP+Y_CORD_WIDTH_LP+NET_ADDR_WIDTH_LP-1:0]];
  logic [ID_WIDTH_LP-1:0]   pool_id [$];
  logic [DATA_WIDTH_LP-1:0] pool_data [$];
  int unsigned              credit_due [$];

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    rand_state = 32'h6d1c;
    cycle = 0;
    credit_ok = 1'b1;
    credit_o = 1'b0;
    resp_v_o = 1'b0;
    resp_id_o = '0;
    resp_data_o = '0;
  end

  // ------------------------------
  // accept packets mid-cycle
  // ------------------------------
  // the tile serves packets in arrival order, only the replies get shuffled
  always @(negedge clk_i)
  begin
    logic [X_CORD_WIDTH_LP+Y_CORD_WIDTH_LP+NET_ADDR_WIDTH_LP-1:0] key;
    logic [DATA_WIDTH_LP-1:0] rd_data;
    credit_ok = !hold_credits_i;
    if (rst_n_i && req_v_i)
    begin
      key = {req_x_i, req_y_i, req_addr_i};
      if (req_op_i == NET_OP_STORE)
      begin
        dram[key] = req_data_i;
        // garbage on purpose, the bridge must zero it
        rd_data = ~req_data_i;
      end
      else if (dram.exists(key))
        rd_data = dram[key];
      else
        rd_data = {4'hf, 2'b00, key};
      pool_id.push_back(req_id_i);
      pool_data.push_back(rd_data);
      rand_state = lcg_next(rand_state);
      credit_due.push_back(cycle + 1 + rand_state[17:16]);
    end
  end

  // ------------------------------
  // replies and credits
  // ------------------------------
  always @(posedge clk_i)
  begin
    int unsigned pick;
    cycle = cycle + 1;
    #2;
    credit_o = 1'b0;
    resp_v_o = 1'b0;
    if (credit_ok && credit_due.size() != 0 && credit_due[0] <= cycle)
    begin
      void'(credit_due.pop_front());
      credit_o = 1'b1;
    end
    rand_state = lcg_next(rand_state);
    if (rst_n_i && pool_id.size() != 0 && rand_state[20:19] != 2'b00)
    begin
      pick = rand_state[31:24] % pool_id.size();
      resp_v_o = 1'b1;
      resp_id_o = pool_id[pick];
      resp_data_o = pool_data[pick];
      pool_id.delete(pick);
      pool_data.delete(pick);
    end
  end

endmodule
